// ==== src/pid_cfg.svh ====
`ifndef PID_CFG_SVH
`define PID_CFG_SVH

// ------------------------------------------------------------
// Sizes
// ------------------------------------------------------------
`define PID_N_CHAN        8
`define PID_W_CHAN        3
`define PID_W_DIN         18
`define PID_W_COEF        16
`define PID_W_DOUT        32
`define PID_W_WR_DATA     32

// Derived datapath widths
`define PID_W_ERROR       (`PID_W_DIN + 1)
`define PID_W_K           (`PID_W_COEF + 2)
`define PID_W_PROD        (`PID_W_ERROR + `PID_W_K)
`define PID_W_DELTA       (`PID_W_PROD + 2)

// Per-channel configuration after reset
`define PID_SETPOINT_INIT 0
`define PID_P_INIT        0
`define PID_I_INIT        0
`define PID_D_INIT        0
`define PID_INV_INIT      1'b0
`define PID_LOCK_EN_INIT  1'b0

`endif

// ==== src/pid_reg_pkg.sv ====
`default_nettype none
`include "pid_cfg.svh"

package pid_reg_pkg;

    // ------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------
    // One address per field of a channel
    typedef enum logic [3:0] {
        LOCK_EN   = 4'd0,
        INV_ERROR = 4'd1,
        SETPOINT  = 4'd2,
        P_COEF    = 4'd3,
        I_COEF    = 4'd4,
        D_COEF    = 4'd5,
        CLR_RQST  = 4'd6
    } pid_reg_addr_e;

    // Single write request
    typedef struct packed {
        logic                      en;
        logic [`PID_W_CHAN-1:0]    chan;
        pid_reg_addr_e             addr;
        logic [`PID_W_WR_DATA-1:0] data;
    } pid_wr_t;

endpackage

`default_nettype wire

// ==== src/pid_dp_pkg.sv ====
`default_nettype none
`include "pid_cfg.svh"

package pid_dp_pkg;

    // Incoming sample
    typedef struct packed {
        logic                        dv;
        logic [`PID_W_CHAN-1:0]      chan;
        logic signed [`PID_W_DIN-1:0] data;
    } pid_sample_t;

    // Controller output
    typedef struct packed {
        logic                         dv;
        logic [`PID_W_CHAN-1:0]       chan;
        logic signed [`PID_W_DOUT-1:0] data;
    } pid_result_t;

    // Stage 1, sample plus channel config
    typedef struct packed {
        logic                          dv;
        logic [`PID_W_CHAN-1:0]        chan;
        logic signed [`PID_W_DIN-1:0]  din;
        logic signed [`PID_W_DIN-1:0]  setpoint;
        logic signed [`PID_W_COEF-1:0] p;
        logic signed [`PID_W_COEF-1:0] i;
        logic signed [`PID_W_COEF-1:0] d;
        logic                          lock_en;
        logic                          inv_error;
    } pid_fetch_t;

    // Stage 3, coefficient times error products
    typedef struct packed {
        logic                          dv;
        logic [`PID_W_CHAN-1:0]        chan;
        logic signed [`PID_W_PROD-1:0] prod1;
        logic signed [`PID_W_PROD-1:0] prod2;
        logic signed [`PID_W_PROD-1:0] prod3;
    } pid_prod_t;

endpackage

`default_nettype wire

// ==== src/pid_fetch_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pid_cfg.svh"

module pid_fetch_stage (
    input  logic                    clk_in,
    input  logic                    arst_n,
    input  pid_reg_pkg::pid_wr_t    wr,
    input  pid_dp_pkg::pid_sample_t smp,
    output pid_dp_pkg::pid_fetch_t  fetch,
    output logic [`PID_N_CHAN-1:0]  clr_vec
);
    import pid_reg_pkg::*;

    // Channel configuration
    logic [`PID_N_CHAN-1:0]        lock_en_mem;
    logic [`PID_N_CHAN-1:0]        inv_error_mem;
    logic signed [`PID_W_DIN-1:0]  setpoint_mem [`PID_N_CHAN];
    logic signed [`PID_W_COEF-1:0] p_mem [`PID_N_CHAN];
    logic signed [`PID_W_COEF-1:0] i_mem [`PID_N_CHAN];
    logic signed [`PID_W_COEF-1:0] d_mem [`PID_N_CHAN];

    logic                   wr_ok;
    logic [`PID_N_CHAN-1:0] clr_next;

    // Out-of-range channels are ignored
    assign wr_ok = wr.en && (wr.chan < `PID_N_CHAN);

    // ------------------------------------------------------------
    // Register writes
    // ------------------------------------------------------------
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < `PID_N_CHAN; c++) begin
                lock_en_mem[c]   <= `PID_LOCK_EN_INIT;
                inv_error_mem[c] <= `PID_INV_INIT;
                setpoint_mem[c]  <= `PID_SETPOINT_INIT;
                p_mem[c]         <= `PID_P_INIT;
                i_mem[c]         <= `PID_I_INIT;
                d_mem[c]         <= `PID_D_INIT;
            end
        end else if (wr_ok) begin
            case (wr.addr)
                LOCK_EN:   lock_en_mem[wr.chan]   <= wr.data[0];
                INV_ERROR: inv_error_mem[wr.chan] <= wr.data[0];
                SETPOINT:  setpoint_mem[wr.chan]  <= wr.data[`PID_W_DIN-1:0];
                P_COEF:    p_mem[wr.chan]         <= wr.data[`PID_W_COEF-1:0];
                I_COEF:    i_mem[wr.chan]         <= wr.data[`PID_W_COEF-1:0];
                D_COEF:    d_mem[wr.chan]         <= wr.data[`PID_W_COEF-1:0];
                default: ;
            endcase
        end
    end

    // Clear request, single cycle per channel
    always_comb begin
        clr_next = '0;
        if (wr_ok && (wr.addr == CLR_RQST) && wr.data[0] && !clr_vec[wr.chan]) begin
            clr_next[wr.chan] = 1'b1;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            clr_vec <= '0;
        end else begin
            clr_vec <= clr_next;
        end
    end

    // ------------------------------------------------------------
    // Stage 1, fetch
    // ------------------------------------------------------------
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            fetch <= '0;
        end else begin
            // Drop samples of a channel being cleared
            fetch.dv        <= smp.dv && !clr_vec[smp.chan];
            fetch.chan      <= smp.chan;
            fetch.din       <= smp.data;
            fetch.setpoint  <= setpoint_mem[smp.chan];
            fetch.p         <= p_mem[smp.chan];
            fetch.i         <= i_mem[smp.chan];
            fetch.d         <= d_mem[smp.chan];
            fetch.lock_en   <= lock_en_mem[smp.chan];
            fetch.inv_error <= inv_error_mem[smp.chan];
        end
    end

    // Clear pulse never lasts two cycles
    a_clr_pulse: assert property (@(posedge clk_in) disable iff (!arst_n)
        ((clr_vec & $past(clr_vec)) == '0))
        else $error("clr_vec held high for two cycles");

endmodule

`default_nettype wire

// ==== src/pid_error_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pid_cfg.svh"

module pid_error_stage (
    input  logic                   clk_in,
    input  logic                   arst_n,
    input  pid_dp_pkg::pid_fetch_t fetch,
    input  logic [`PID_N_CHAN-1:0] clr_vec,
    output pid_dp_pkg::pid_prod_t  prod
);

    // Error history per channel
    logic signed [`PID_W_ERROR-1:0] err_prev1_mem [`PID_N_CHAN];
    logic signed [`PID_W_ERROR-1:0] err_prev2_mem [`PID_N_CHAN];

    logic                           flush2;
    logic signed [`PID_W_ERROR-1:0] err_raw;
    logic signed [`PID_W_ERROR-1:0] err_new;
    logic signed [`PID_W_K-1:0]     k1_new;
    logic signed [`PID_W_K-1:0]     k2_new;
    logic signed [`PID_W_K-1:0]     k3_new;

    // Stage 2 registers
    logic                           dv2;
    logic [`PID_W_CHAN-1:0]         chan2;
    logic signed [`PID_W_ERROR-1:0] err2;
    logic signed [`PID_W_ERROR-1:0] prev1_2;
    logic signed [`PID_W_ERROR-1:0] prev2_2;
    logic signed [`PID_W_K-1:0]     k1_2;
    logic signed [`PID_W_K-1:0]     k2_2;
    logic signed [`PID_W_K-1:0]     k3_2;

    // ------------------------------------------------------------
    // Stage 2, error and z-domain coefficients
    // ------------------------------------------------------------
    always_comb begin
        // Unlocked channels produce nothing
        flush2  = clr_vec[fetch.chan] || !fetch.lock_en;
        err_raw = $signed(fetch.setpoint) - $signed(fetch.din);
        // Inverted error is -e-1
        err_new = fetch.inv_error ? ~err_raw : err_raw;
        k1_new  = $signed(fetch.p) + $signed(fetch.i) + $signed(fetch.d);
        k2_new  = -$signed(fetch.p) - ($signed(fetch.d) <<< 1);
        k3_new  = $signed(fetch.d);
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            dv2     <= 1'b0;
            chan2   <= '0;
            err2    <= '0;
            prev1_2 <= '0;
            prev2_2 <= '0;
            k1_2    <= '0;
            k2_2    <= '0;
            k3_2    <= '0;
        end else begin
            dv2     <= fetch.dv && !flush2;
            chan2   <= fetch.chan;
            err2    <= err_new;
            prev1_2 <= err_prev1_mem[fetch.chan];
            prev2_2 <= err_prev2_mem[fetch.chan];
            k1_2    <= k1_new;
            k2_2    <= k2_new;
            k3_2    <= k3_new;
        end
    end

    // ------------------------------------------------------------
    // Stage 3, history writeback and products
    // ------------------------------------------------------------
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < `PID_N_CHAN; c++) begin
                err_prev1_mem[c] <= '0;
                err_prev2_mem[c] <= '0;
            end
        end else begin
            if (dv2) begin
                err_prev1_mem[chan2] <= err2;
                err_prev2_mem[chan2] <= prev1_2;
            end
            // Clear wins over writeback
            for (int c = 0; c < `PID_N_CHAN; c++) begin
                if (clr_vec[c]) begin
                    err_prev1_mem[c] <= '0;
                    err_prev2_mem[c] <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            prod <= '0;
        end else begin
            prod.dv    <= dv2 && !clr_vec[chan2];
            prod.chan  <= chan2;
            prod.prod1 <= k1_2 * err2;
            prod.prod2 <= k2_2 * prev1_2;
            prod.prod3 <= k3_2 * prev2_2;
        end
    end

    // Lock gating upstream of any valid item
    a_lock_gate: assert property (@(posedge clk_in) disable iff (!arst_n)
        dv2 |-> $past(fetch.lock_en))
        else $error("stage 2 item valid without lock_en");

endmodule

`default_nettype wire

// ==== src/pid_accum_stage.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pid_cfg.svh"

module pid_accum_stage (
    input  logic                    clk_in,
    input  logic                    arst_n,
    input  pid_dp_pkg::pid_prod_t   prod,
    input  logic [`PID_N_CHAN-1:0]  clr_vec,
    output pid_dp_pkg::pid_result_t res
);

    // Unclamped sum needs one bit above the wider operand
    localparam int W_SUM = ((`PID_W_DOUT > `PID_W_DELTA) ? `PID_W_DOUT : `PID_W_DELTA) + 1;
    localparam logic signed [`PID_W_DOUT-1:0] MAX_DOUT = {1'b0, {(`PID_W_DOUT-1){1'b1}}};
    localparam logic signed [`PID_W_DOUT-1:0] MIN_DOUT = {1'b1, {(`PID_W_DOUT-1){1'b0}}};

    // Previous output per channel
    logic signed [`PID_W_DOUT-1:0] dout_mem [`PID_N_CHAN];

    // Stage 4
    logic                          dv4;
    logic [`PID_W_CHAN-1:0]        chan4;
    logic signed [`PID_W_DELTA-1:0] delta4;
    logic signed [`PID_W_DOUT-1:0] dout_prev4;

    // Stage 5
    logic signed [W_SUM-1:0]       sum5;
    logic                          dv5;
    logic [`PID_W_CHAN-1:0]        chan5;
    logic signed [`PID_W_DOUT-1:0] dout5;

    // ------------------------------------------------------------
    // Stage 4, delta and previous output
    // ------------------------------------------------------------
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            dv4        <= 1'b0;
            chan4      <= '0;
            delta4     <= '0;
            dout_prev4 <= '0;
        end else begin
            dv4        <= prod.dv && !clr_vec[prod.chan];
            chan4      <= prod.chan;
            delta4     <= prod.prod1 + prod.prod2 + prod.prod3;
            dout_prev4 <= dout_mem[prod.chan];
        end
    end

    // ------------------------------------------------------------
    // Stage 5, accumulate and saturate
    // ------------------------------------------------------------
    assign sum5 = dout_prev4 + delta4;

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            dv5   <= 1'b0;
            chan5 <= '0;
            dout5 <= '0;
        end else begin
            dv5   <= dv4 && !clr_vec[chan4];
            chan5 <= chan4;
            if (sum5 > MAX_DOUT) begin
                dout5 <= MAX_DOUT;
            end else if (sum5 < MIN_DOUT) begin
                dout5 <= MIN_DOUT;
            end else begin
                dout5 <= sum5[`PID_W_DOUT-1:0];
            end
        end
    end

    // ------------------------------------------------------------
    // Stage 6, output history and result
    // ------------------------------------------------------------
    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            for (int c = 0; c < `PID_N_CHAN; c++) begin
                dout_mem[c] <= '0;
            end
        end else begin
            if (dv5) begin
                dout_mem[chan5] <= dout5;
            end
            for (int c = 0; c < `PID_N_CHAN; c++) begin
                if (clr_vec[c]) begin
                    dout_mem[c] <= '0;
                end
            end
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            res <= '0;
        end else begin
            res.dv   <= dv5 && !clr_vec[chan5];
            res.chan <= chan5;
            res.data <= dout5;
        end
    end

    a_res_chan: assert property (@(posedge clk_in) disable iff (!arst_n)
        res.dv |-> (res.chan < `PID_N_CHAN))
        else $error("result on channel %0d out of range", res.chan);

endmodule

`default_nettype wire

// ==== src/pid_top.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pid_cfg.svh"

module pid_top (
    input  logic                    clk_in,
    input  logic                    arst_n,
    input  pid_reg_pkg::pid_wr_t    wr,
    input  pid_dp_pkg::pid_sample_t smp,
    output pid_dp_pkg::pid_result_t res
);
    import pid_dp_pkg::*;

    // Stage-to-stage links
    pid_fetch_t             fetch;
    pid_prod_t              prod;
    // Clear pulses go to every stage
    logic [`PID_N_CHAN-1:0] clr_vec;

    // ------------------------------------------------------------
    // Config, clear and stage 1
    // ------------------------------------------------------------
    pid_fetch_stage u_fetch (
        .clk_in  (clk_in),
        .arst_n  (arst_n),
        .wr      (wr),
        .smp     (smp),
        .fetch   (fetch),
        .clr_vec (clr_vec)
    );

    // Stages 2 and 3
    pid_error_stage u_error (
        .clk_in  (clk_in),
        .arst_n  (arst_n),
        .fetch   (fetch),
        .clr_vec (clr_vec),
        .prod    (prod)
    );

    // Stages 4 to 6
    pid_accum_stage u_accum (
        .clk_in  (clk_in),
        .arst_n  (arst_n),
        .prod    (prod),
        .clr_vec (clr_vec),
        .res     (res)
    );

endmodule

`default_nettype wire

// ==== test/pid_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "pid_cfg.svh"

module pid_tb;
    import pid_reg_pkg::*;
    import pid_dp_pkg::*;

    localparam int MIN_GAP     = 6;
    localparam int RES_TIMEOUT = 20;
    localparam int DRAIN_LIMIT = 40;

    // One table row, either a register write or a sample
    typedef struct packed {
        logic                      is_smp;
        logic                      has_res;
        logic [`PID_W_CHAN-1:0]    chan;
        pid_reg_addr_e             addr;
        logic [`PID_W_WR_DATA-1:0] data;
        logic [`PID_W_DOUT-1:0]    exp_data;
    } row_t;

    // Result still in flight
    typedef struct packed {
        logic [`PID_W_CHAN-1:0] chan;
        logic [`PID_W_DOUT-1:0] data;
    } exp_t;

    logic        clk_in;
    logic        arst_n;
    pid_wr_t     wr;
    pid_sample_t smp;
    pid_result_t res;

    row_t rows [$];
    exp_t exp_q [$];
    int   errors = 0;
    int   checks = 0;

    pid_top dut (
        .clk_in (clk_in),
        .arst_n (arst_n),
        .wr     (wr),
        .smp    (smp),
        .res    (res)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    task automatic add_write(input int chan, input pid_reg_addr_e addr, input int data);
        row_t r;
        r      = '0;
        r.chan = chan[`PID_W_CHAN-1:0];
        r.addr = addr;
        r.data = data;
        rows.push_back(r);
    endtask

    task automatic add_sample(input int chan, input int din, input logic has_res, input int exp);
        row_t r;
        r          = '0;
        r.is_smp   = 1'b1;
        r.has_res  = has_res;
        r.chan     = chan[`PID_W_CHAN-1:0];
        r.data     = din;
        r.exp_data = exp;
        rows.push_back(r);
    endtask

    // ------------------------------------------------------------
    // Stimulus table, expected outputs worked out by hand
    // ------------------------------------------------------------
    task automatic build_table();
        // P only, k1=2 k2=-2
        add_write(0, LOCK_EN, 1);
        add_write(0, SETPOINT, 100);
        add_write(0, P_COEF, 2);
        add_sample(0, 90, 1'b1, 20);
        add_sample(0, 95, 1'b1, 10);
        add_sample(0, 100, 1'b1, 0);
        // Full PID, k1=6 k2=-5 k3=1
        add_write(1, LOCK_EN, 1);
        add_write(1, SETPOINT, 1000);
        add_write(1, P_COEF, 3);
        add_write(1, I_COEF, 2);
        add_write(1, D_COEF, 1);
        add_sample(1, 900, 1'b1, 600);
        add_sample(1, 950, 1'b1, 400);
        add_sample(1, 980, 1'b1, 370);
        // Interleaved channels 2 and 3
        add_write(2, LOCK_EN, 1);
        add_write(2, SETPOINT, 50);
        add_write(2, P_COEF, 1);
        add_write(2, I_COEF, 1);
        add_write(3, LOCK_EN, 1);
        add_write(3, SETPOINT, -50);
        add_write(3, P_COEF, 4);
        add_sample(2, 40, 1'b1, 20);
        add_sample(3, -60, 1'b1, 40);
        add_sample(2, 45, 1'b1, 20);
        add_sample(3, -70, 1'b1, 80);
        // Lock off gives nothing, then inverted error -e-1
        add_write(4, SETPOINT, 10);
        add_write(4, P_COEF, 1);
        add_sample(4, 4, 1'b0, 0);
        add_write(4, INV_ERROR, 1);
        add_write(4, LOCK_EN, 1);
        add_sample(4, 4, 1'b1, -7);
        add_sample(4, 8, 1'b1, -3);
        // Saturation high then low
        add_write(5, LOCK_EN, 1);
        add_write(5, SETPOINT, 100000);
        add_write(5, P_COEF, 32767);
        add_sample(5, -100000, 1'b1, 32'h7fff_ffff);
        add_sample(5, 100000, 1'b1, 32'h8000_0000);
        // Clear restarts channel 1 from empty history
        add_write(1, CLR_RQST, 1);
        add_sample(1, 980, 1'b1, 120);
    endtask

    // ------------------------------------------------------------
    // Result checker
    // ------------------------------------------------------------
    initial begin
        exp_t head;
        int   stall;
        stall = 0;
        forever begin
            @(negedge clk_in);
            if (arst_n && res.dv) begin
                stall = 0;
                if (exp_q.size() == 0) begin
                    $display("Unexpected result on channel %0d with no sample pending", res.chan);
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    checks++;
                    if (res.chan !== head.chan) begin
                        $display("Fail res.chan: got 0x%h, expected 0x%h", res.chan, head.chan);
                        errors++;
                    end
                    if (res.data !== head.data) begin
                        $display("Fail res.data: got 0x%h, expected 0x%h", res.data, head.data);
                        errors++;
                    end
                end
            end else if (exp_q.size() != 0) begin
                stall++;
                // Give up on the oldest pending result
                if (stall > RES_TIMEOUT) begin
                    head = exp_q.pop_front();
                    $display("Timeout waiting for a result on channel %0d", head.chan);
                    errors++;
                    stall = 0;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Reset, table loop and closing report
    // ------------------------------------------------------------
    initial begin
        row_t        row;
        exp_t        item;
        pid_wr_t     w;
        pid_sample_t s;
        logic        gap;
        int          cycle;
        int          guard;
        int          last_evt [`PID_N_CHAN];

        arst_n = 1'b0;
        wr     = '0;
        smp    = '0;
        cycle  = 0;
        for (int c = 0; c < `PID_N_CHAN; c++) begin
            last_evt[c] = -MIN_GAP;
        end
        build_table();

        repeat (5) @(posedge clk_in);
        arst_n <= 1'b1;

        foreach (rows[r]) begin
            row = rows[r];
            // Samples and clears of one channel stay MIN_GAP apart
            gap = row.is_smp || (row.addr == CLR_RQST);
            while (gap && (cycle + 1 - last_evt[row.chan] < MIN_GAP)) begin
                @(posedge clk_in);
                wr  <= '0;
                smp <= '0;
                cycle++;
            end
            @(posedge clk_in);
            cycle++;
            if (gap) begin
                last_evt[row.chan] = cycle;
            end
            w = '0;
            s = '0;
            if (row.is_smp) begin
                s.dv   = 1'b1;
                s.chan = row.chan;
                s.data = row.data[`PID_W_DIN-1:0];
                if (row.has_res) begin
                    item.chan = row.chan;
                    item.data = row.exp_data;
                    exp_q.push_back(item);
                end
            end else begin
                w.en   = 1'b1;
                w.chan = row.chan;
                w.addr = row.addr;
                w.data = row.data;
            end
            wr  <= w;
            smp <= s;
        end
        @(posedge clk_in);
        wr  <= '0;
        smp <= '0;

        // Drain the pipeline
        guard = 0;
        while (exp_q.size() != 0 && guard < DRAIN_LIMIT) begin
            @(posedge clk_in);
            guard++;
        end
        if (exp_q.size() != 0) begin
            $display("Timed out with %0d results still pending", exp_q.size());
            errors++;
        end
        repeat (4) @(posedge clk_in);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/pid_reg_pkg.sv
src/pid_dp_pkg.sv
src/pid_fetch_stage.sv
src/pid_error_stage.sv
src/pid_accum_stage.sv
src/pid_top.sv
test/pid_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PID controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/10ps \
    --top-module pid_tb \
    -f files.f

./obj_dir/Vpid_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
echo "Simulation finished without failure"
